//--- logic/memConsts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Bus widths seen by the CPU
`define WORD_BITS 32           // Data word
`define ADDR_BITS 32           // Byte address

// Physical RAM, 4096 words = 16 KB = 4 frames
`define RAM_ADDR_BITS 12       // Word address width
`define RAM_DEPTH (1 << `RAM_ADDR_BITS)

// Direct-mapped page map
`define MAP_INDEX_BITS 4       // Low VPN bits pick the entry
`define MAP_ENTRIES (1 << `MAP_INDEX_BITS)

// Pages are 4 KB
`define PAGE_OFFSET_BITS 12    // Byte offset inside a page
`define PAGE_NUMBER_BITS (`ADDR_BITS - `PAGE_OFFSET_BITS)

`endif

//--- logic/memBusPkg.sv
`include "memConsts.svh"

package memBusPkg;

  typedef logic [`WORD_BITS-1:0] word_t;          // One data word
  typedef logic [`ADDR_BITS-1:0] addr_t;          // Byte address
  typedef logic [`RAM_ADDR_BITS-1:0] ramAddr_t;   // Word index into the RAM

  // CPU load/store port, strobes sampled only when controller is idle
  typedef struct packed
  {
    addr_t address;      // Word-aligned byte address
    word_t writeData;    // Store data
    logic  read;         // Load strobe, wins over write
    logic  write;        // Store strobe
    logic  isVirtual;    // Address goes through page map
  } memRequest_t;

  // Back to the CPU
  typedef struct packed
  {
    word_t readData;     // Held until next completed load
    logic  ready;        // One-cycle completion pulse
    logic  fault;        // Page fault, valid with ready
  } memResponse_t;

  // Controller to physical RAM
  typedef struct packed
  {
    addr_t address;      // Physical byte address
    word_t writeData;    // Store data
    logic  read;         // One-cycle read strobe
    logic  write;        // One-cycle write strobe
  } phRequest_t;

endpackage

//--- logic/translatePkg.sv
`include "memConsts.svh"

package translatePkg;

  typedef logic [`PAGE_NUMBER_BITS-1:0] vpn_t;    // Virtual page number
  typedef logic [`PAGE_NUMBER_BITS-1:0] ppn_t;    // Physical frame number
  typedef logic [`MAP_INDEX_BITS-1:0] mapIndex_t; // Entry select, low VPN bits

  // Remaining VPN bits, kept in the entry to tell pages apart
  typedef logic [`PAGE_NUMBER_BITS-`MAP_INDEX_BITS-1:0] mapTag_t;

  // One slot of the page map
  typedef struct packed
  {
    logic    valid;      // Slot holds a mapping
    mapTag_t tag;        // Upper VPN bits of the mapped page
    ppn_t    frame;      // Where that page lives
  } mapEntry_t;

  // Map write from outside, one entry per strobe
  typedef struct packed
  {
    logic write;         // Update strobe
    vpn_t vpn;           // Page being mapped
    ppn_t ppn;           // Frame it maps to
  } mapUpdate_t;

endpackage

//--- logic/memoryController.sv
`include "memConsts.svh"

module memoryController
  import memBusPkg::*, translatePkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  memRequest_t  request,       // From CPU
  output memResponse_t response,      // To CPU
  output vpn_t         lookupVpn,     // Page being translated
  input  logic         lookupHit,     // Page map has it
  input  ppn_t         lookupFrame,   // Frame for lookupVpn
  output phRequest_t   phRequest,     // To physical RAM
  input  word_t        ramReadData    // Registered RAM output
);

  // Access sequencing
  typedef enum logic [1:0]
  {
    ready,               // Idle, watching for strobes
    translate,           // Waiting on page map result
    pRamWait1,           // RAM samples the request
    pRamWait2            // RAM data available
  } mcState_t;

  mcState_t state;
  logic     accept;      // Request taken this edge
  logic     isRead;      // Accepted request is a load

  // Captured request
  addr_t    reqAddress;

  // RAM side registers
  addr_t    phAddress;
  word_t    phWriteData;
  logic     phRead;
  logic     phWrite;

  // Response registers
  word_t    respReadData;
  logic     respReady;
  logic     respFault;

  assign accept = (state == ready) && (request.read || request.write);  // Busy strobes dropped

  // Page number of the held request
  assign lookupVpn = reqAddress[`ADDR_BITS-1:`PAGE_OFFSET_BITS];

  assign phRequest = '{
    address:   phAddress,
    writeData: phWriteData,
    read:      phRead,
    write:     phWrite
  };

  assign response = '{
    readData: respReadData,
    ready:    respReady,
    fault:    respFault
  };

  // State and strobes
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state     <= ready;
      isRead    <= 1'b0;
      phRead    <= 1'b0;
      phWrite   <= 1'b0;
      respReady <= 1'b0;
      respFault <= 1'b0;
    end
    else
    begin
      case (state)
        ready:
        begin
          respReady <= 1'b0;                  // End of completion pulse
          respFault <= 1'b0;
          if (accept)
          begin
            isRead <= request.read;           // Read wins if both set
            if (request.isVirtual)
            begin
              state <= translate;             // Page map answers next cycle
            end
            else
            begin
              phRead  <= request.read;        // Straight to RAM
              phWrite <= request.write && !request.read;
              state   <= pRamWait1;
            end
          end
        end

        translate:
        begin
          if (lookupHit)
          begin
            phRead  <= isRead;                // Issue against the frame
            phWrite <= !isRead;
            state   <= pRamWait1;
          end
          else
          begin
            respReady <= 1'b1;                // Miss, fault right away
            respFault <= 1'b1;
            state     <= ready;
          end
        end

        pRamWait1:
        begin
          phRead  <= 1'b0;                    // Strobes last one cycle
          phWrite <= 1'b0;
          state   <= pRamWait2;
        end

        pRamWait2:
        begin
          respReady <= 1'b1;                  // Done, data captured below
          state     <= ready;
        end

        default:
        begin
          state <= ready;
        end
      endcase
    end
  end

  // Address and data path
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      reqAddress  <= request.address;
      phAddress   <= request.address;         // Used as is when physical
      phWriteData <= request.writeData;
    end

    if (state == translate && lookupHit)
    begin
      // Frame replaces the page number, offset kept
      phAddress <= {lookupFrame, reqAddress[`PAGE_OFFSET_BITS-1:0]};
    end

    if (state == pRamWait2 && isRead)
    begin
      respReadData <= ramReadData;            // Held until next load
    end
  end

endmodule

//--- logic/pageMap.sv
`include "memConsts.svh"

module pageMap
  import translatePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  mapUpdate_t mapUpdate,    // Entry write from outside
  input  vpn_t       lookupVpn,    // Page to translate
  output logic       lookupHit,    // Valid entry with matching tag
  output ppn_t       lookupFrame   // Frame of that entry
);

  mapEntry_t entries [`MAP_ENTRIES];  // One entry per index

  // Lookup side
  mapIndex_t lookupIndex;
  mapTag_t   lookupTag;
  mapEntry_t lookupEntry;

  // Update side
  mapIndex_t updateIndex;
  mapEntry_t updateEntry;

  // Split the VPN into index and tag
  assign lookupIndex = lookupVpn[`MAP_INDEX_BITS-1:0];
  assign lookupTag   = lookupVpn[`PAGE_NUMBER_BITS-1:`MAP_INDEX_BITS];

  assign updateIndex = mapUpdate.vpn[`MAP_INDEX_BITS-1:0];

  // New entry is always valid
  assign updateEntry = '{
    valid: 1'b1,
    tag:   mapUpdate.vpn[`PAGE_NUMBER_BITS-1:`MAP_INDEX_BITS],
    frame: mapUpdate.ppn
  };

  // Last update to an index wins
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MAP_ENTRIES; i++)
      begin
        entries[i] <= '0;                     // All invalid
      end
    end
    else if (mapUpdate.write)
    begin
      entries[updateIndex] <= updateEntry;
    end
  end

  // Combinational lookup sees the entries before this edge's update
  assign lookupEntry = entries[lookupIndex];

  assign lookupHit   = lookupEntry.valid && (lookupEntry.tag == lookupTag);
  assign lookupFrame = lookupEntry.frame;     // Only meaningful on hit

endmodule

//--- logic/physicalRam.sv
`include "memConsts.svh"

module physicalRam
  import memBusPkg::*;
(
  input  logic       clk,
  input  phRequest_t phRequest,   // Strobed access from controller
  output word_t      readData     // Valid one edge after read
);

  word_t    mem [`RAM_DEPTH];     // Block RAM array, no reset
  ramAddr_t wordAddr;             // Word index of the access

  // Drop byte bits, wrap above 16 KB
  assign wordAddr = phRequest.address[`RAM_ADDR_BITS+1:2];

  // Single port, read returns old data on collision
  always_ff @(posedge clk)
  begin
    if (phRequest.write)
    begin
      mem[wordAddr] <= phRequest.writeData;
    end

    if (phRequest.read)
    begin
      readData <= mem[wordAddr];              // Holds until next read
    end
  end

endmodule

//--- logic/memorySubsystem.sv
module memorySubsystem
  import memBusPkg::*, translatePkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  memRequest_t  request,     // CPU load/store
  output memResponse_t response,    // Completion back to CPU
  input  mapUpdate_t   mapUpdate    // Page map writes
);

  // Controller to page map
  vpn_t       lookupVpn;
  logic       lookupHit;
  ppn_t       lookupFrame;

  // Controller to RAM
  phRequest_t phRequest;
  word_t      ramReadData;

  // Sequences every access
  memoryController controller
  (
    .clk         (clk),
    .reset       (reset),
    .request     (request),
    .response    (response),
    .lookupVpn   (lookupVpn),
    .lookupHit   (lookupHit),
    .lookupFrame (lookupFrame),
    .phRequest   (phRequest),
    .ramReadData (ramReadData)
  );

  // Virtual to physical translation
  pageMap map
  (
    .clk         (clk),
    .reset       (reset),
    .mapUpdate   (mapUpdate),
    .lookupVpn   (lookupVpn),
    .lookupHit   (lookupHit),
    .lookupFrame (lookupFrame)
  );

  // 16 KB word RAM
  physicalRam ram
  (
    .clk         (clk),
    .phRequest   (phRequest),
    .readData    (ramReadData)
  );

endmodule

//--- tb/memorySubsystemTb.sv
`include "memConsts.svh"

module memorySubsystemTb
  import memBusPkg::*, translatePkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Test sizes
  localparam int RESET_CYCLES   = 16;
  localparam int QUIET_CYCLES   = 8;     // Idle after reset with response low
  localparam int UNMAPPED_COUNT = 4;     // Virtual accesses on an empty map
  localparam int RANDOM_PAIRS   = 200;   // Physical write then read back
  localparam int VIRT_COUNT     = 24;    // Map, write, read, physical cross-check
  localparam int STALE_COUNT    = 8;     // Index taken over by another tag
  localparam int BUSY_COUNT     = 16;    // Accesses with strobes while busy
  localparam int MAX_TX_CYCLES  = 5;     // Virtual hit plus the cycle after ready

  localparam int TX_COUNT = UNMAPPED_COUNT + 2 * RANDOM_PAIRS + 3 * VIRT_COUNT
                          + 4 * STALE_COUNT + 4 * BUSY_COUNT;
  localparam int UPDATE_COUNT = VIRT_COUNT + 2 * STALE_COUNT + BUSY_COUNT;
  localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + QUIET_CYCLES
                                         + TX_COUNT * MAX_TX_CYCLES + UPDATE_COUNT + 1000;

  logic         clk;
  logic         reset;
  memRequest_t  request;
  memResponse_t response;
  mapUpdate_t   mapUpdate;

  // Reference model of RAM and page map
  word_t     memModel [`RAM_DEPTH];
  mapEntry_t mapModel [`MAP_ENTRIES];
  ramAddr_t  writtenWords [$];           // Words holding a known value

  // Expectation for the request in flight
  string       testName;
  logic        outstanding;              // Accepted and ready not yet checked
  logic        expIsRead;
  logic        expFault;
  word_t       expData;
  int unsigned expLatency;               // Edges from acceptance to ready
  int unsigned acceptCycle;
  int unsigned cycle = 0;                // Edges since time zero
  int          seed;

  memorySubsystem UUT
  (
    .clk       (clk),
    .reset     (reset),
    .request   (request),
    .response  (response),
    .mapUpdate (mapUpdate)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;               // 8 ns period
  end

  // Edge count and run limit
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES)
    begin
      failRun($sformatf("Timeout, run still going after %0d cycles", cycle));
    end
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  // Nothing may come back without a request
  quietWhenIdle: assert property (@(posedge clk) disable iff (reset)
    !outstanding |-> !response.ready && !response.fault)
    else failRun("Ready or fault seen with no request outstanding");

  faultWithReady: assert property (@(posedge clk) disable iff (reset)
    response.fault |-> response.ready)
    else failRun("Fault raised outside a ready pulse");

  latencyCheck: assert property (@(posedge clk) disable iff (reset)
    response.ready |-> (cycle - acceptCycle) == expLatency)
    else failRun($sformatf("** Error %s: latency expected %0d actual %0d",
                           testName, expLatency, $sampled(cycle) - acceptCycle));

  faultCheck: assert property (@(posedge clk) disable iff (reset)
    response.ready |-> response.fault == expFault)
    else failRun($sformatf("** Error %s: fault expected %0b actual %0b",
                           testName, expFault, $sampled(response.fault)));

  dataCheck: assert property (@(posedge clk) disable iff (reset)
    response.ready && expIsRead && !expFault |-> response.readData == expData)
    else failRun($sformatf("** Error %s: readData expected %08h actual %08h",
                           testName, expData, $sampled(response.readData)));

  function automatic word_t randomWord();
    return $random(seed);
  endfunction

  function automatic addr_t randomAddr();
    addr_t a;
    a = randomWord();
    a[1:0] = 2'b00;                      // Word aligned
    return a;
  endfunction

  // RAM decodes byte bits 13..2 and higher bits wrap
  function automatic ramAddr_t wordIndex(input addr_t physAddr);
    return physAddr[13:2];
  endfunction

  // Direct-mapped lookup with index vpn[3:0] and tag vpn[19:4]
  function automatic logic translateModel(input addr_t virtAddr, output addr_t physAddr);
    mapEntry_t entry;
    entry = mapModel[virtAddr[15:12]];
    physAddr = {entry.frame, virtAddr[11:0]};   // Frame then page offset
    return entry.valid && (entry.tag == virtAddr[31:16]);
  endfunction

  function automatic ramAddr_t pickWritten();
    int unsigned idx;
    idx = $unsigned($random(seed)) % writtenWords.size();
    return writtenWords[idx];
  endfunction

  // Step to 1 ns past the next rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic updateMap(input vpn_t vpn, input ppn_t ppn);
    mapUpdate = '{write: 1'b1, vpn: vpn, ppn: ppn};
    mapModel[vpn[3:0]] = '{valid: 1'b1, tag: vpn[19:4], frame: ppn};
    tick();
    mapUpdate = '0;
  endtask

  // One request with optional strobes at junkWord while busy
  task automatic access(input string name, input addr_t address, input word_t data,
                        input logic doRead, input logic isVirtual, input logic noisy,
                        input ramAddr_t junkWord);
    addr_t physAddr;
    logic  hit;
    word_t noise;
    hit = 1'b1;
    physAddr = address;
    if (isVirtual)
    begin
      hit = translateModel(address, physAddr);
    end
    testName    = name;
    expIsRead   = doRead;
    expFault    = !hit;
    expLatency  = !isVirtual ? 2 : (hit ? 3 : 1);
    expData     = memModel[wordIndex(physAddr)];
    if (!doRead && hit)
    begin
      memModel[wordIndex(physAddr)] = data;     // Faulted writes leave model alone
      writtenWords.push_back(wordIndex(physAddr));
    end
    request = '{address: address, writeData: data, read: doRead, write: !doRead,
                isVirtual: isVirtual};
    acceptCycle = cycle + 1;             // Idle controller takes it at next edge
    outstanding = 1'b1;
    tick();
    request = '0;
    while (!response.ready)
    begin
      if (noisy)
      begin
        noise = randomWord();
        request = '{address: addr_t'(junkWord) << 2, writeData: randomWord(),
                    read: noise[0], write: 1'b1, isVirtual: 1'b0};
      end
      tick();
      request = '0;                      // Never strobe into the ready cycle
    end
    tick();                              // Checks sample the ready pulse here
    outstanding = 1'b0;
  endtask

  initial
  begin
    vpn_t     vpn;
    vpn_t     otherVpn;
    ppn_t     ppn;
    addr_t    addr;
    addr_t    vaddr;
    addr_t    paddr;
    word_t    r;
    ramAddr_t junk;

    seed        = 32'hb051;
    reset       = 1'b1;
    request     = '0;
    mapUpdate   = '0;
    outstanding = 1'b0;
    expIsRead   = 1'b0;
    expFault    = 1'b0;
    expData     = '0;
    expLatency  = 0;
    acceptCycle = 0;
    testName    = "reset";
    for (int i = 0; i < `MAP_ENTRIES; i++)
    begin
      mapModel[i] = '0;                  // Empty map after reset
    end

    repeat (RESET_CYCLES) tick();
    reset = 1'b0;
    repeat (QUIET_CYCLES) tick();

    for (int i = 0; i < UNMAPPED_COUNT; i++)
    begin
      access("unmappedFault", randomAddr(), randomWord(), i[0], 1'b1, 1'b0, '0);
    end

    for (int i = 0; i < RANDOM_PAIRS; i++)
    begin
      addr = randomAddr();
      access("physWrite", addr, randomWord(), 1'b0, 1'b0, 1'b0, '0);
      access("physRead", addr, '0, 1'b1, 1'b0, 1'b0, '0);
    end

    for (int i = 0; i < VIRT_COUNT; i++)
    begin
      r = randomWord();
      vpn = r[19:0];
      r = randomWord();
      ppn = r[19:0];
      updateMap(vpn, ppn);
      r = randomWord();
      vaddr = {vpn, r[11:2], 2'b00};
      paddr = {ppn, r[11:2], 2'b00};
      access("virtWrite", vaddr, randomWord(), 1'b0, 1'b1, 1'b0, '0);
      access("virtRead", vaddr, '0, 1'b1, 1'b1, 1'b0, '0);
      access("virtCrossCheck", paddr, '0, 1'b1, 1'b0, 1'b0, '0);
    end

    for (int i = 0; i < STALE_COUNT; i++)
    begin
      r = randomWord();
      vpn = r[19:0];
      r = randomWord();
      ppn = r[19:0];
      otherVpn = vpn ^ 20'h10;           // Same index with tag bit 0 flipped
      r = randomWord();
      vaddr = {vpn, r[11:2], 2'b00};
      paddr = {ppn, r[11:2], 2'b00};
      updateMap(vpn, ppn);
      access("staleSetup", paddr, randomWord(), 1'b0, 1'b0, 1'b0, '0);
      updateMap(otherVpn, ppn);          // Entry now holds another tag
      access("staleWrite", vaddr, randomWord(), 1'b0, 1'b1, 1'b0, '0);
      access("staleRead", vaddr, '0, 1'b1, 1'b1, 1'b0, '0);
      access("staleUnchanged", paddr, '0, 1'b1, 1'b0, 1'b0, '0);
    end

    for (int i = 0; i < BUSY_COUNT; i++)
    begin
      junk = pickWritten();              // Ignored writes aim at a known word
      access("busyPhysWrite", randomAddr(), randomWord(), 1'b0, 1'b0, 1'b1, junk);
      r = randomWord();
      vpn = r[19:0];
      r = randomWord();
      ppn = r[19:0];
      updateMap(vpn, ppn);
      r = randomWord();
      vaddr = {vpn, r[11:2], 2'b00};
      access("busyVirtWrite", vaddr, randomWord(), 1'b0, 1'b1, 1'b1, junk);
      access("busyVirtRead", vaddr, '0, 1'b1, 1'b1, 1'b1, junk);
      access("busyJunkCheck", addr_t'(junk) << 2, '0, 1'b1, 1'b0, 1'b0, '0);
    end

    $display("TEST OK");
    $finish;
  end

endmodule

//--- files.f
+incdir+logic
logic/memBusPkg.sv
logic/translatePkg.sv
logic/memoryController.sv
logic/pageMap.sv
logic/physicalRam.sv
logic/memorySubsystem.sv
tb/memorySubsystemTb.sv

//--- Makefile
# Verilator build and run of the memory subsystem testbench
# Exit status of the simulation is the pass/fail result

VERILATOR ?= verilator
TOP       ?= memorySubsystemTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
